// File: verilog/uopPkg.sv
// Micro-op expander shared types, register map and instruction encoding constants
package uopPkg;

	// Control bits that travel with every micro-op into the pipeline
	typedef struct packed {
		logic instrMux;      // Micro-op replaces the decoded instruction
		logic noFlagUpdate;  // Suppress flag write in execute
		logic holdFetch;     // More micro-ops follow, fetch keeps instr
		logic ldmForward;    // Later LDM/STM transfer
		logic prevRsr;       // Second half of a register-shifted op
		logic keepV;         // Preserve V flag
		logic noRotate;      // imm12 used as plain offset, no rotate
	} uopCtrl_t;

	// Sequencer states, one per multi-cycle class plus the LDM writeback step
	typedef enum logic [2:0] {
		stReady,
		stRsr,
		stBl,
		stLdm,
		stLdmWriteback,
		stPostIndex
	} seqState_t;

	// Bit positions in the enable register
	localparam int enRsr = 0;
	localparam int enBl = 1;
	localparam int enLdm = 2;
	localparam int enPost = 3;
	localparam int classCount = 4;

	// AXI4-Lite register map
	localparam logic [3:0] addrCtrl = 4'h0;   // Class enables, RW
	localparam logic [3:0] addrCount = 4'h4;  // Expansion counter, write clears
	localparam logic [classCount-1:0] ctrlResetValue = 4'b1111;

	// AXI response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Register numbers
	localparam logic [3:0] regZ = 4'hF;     // Scratch Rz, fifth bit comes from regFileRz
	localparam logic [3:0] regLink = 4'hE;
	localparam logic [3:0] regPc = 4'hF;

	// Data processing opcodes
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] opSub = 4'b0010;
	localparam logic [3:0] opMov = 4'b1101;

endpackage

// File: verilog/uopCondCheck.sv
// Condition check, evaluates an ARM condition field against the N Z C V flags
`timescale 1ns/1ps

module uopCondCheck (
	input  logic [3:0] cond,
	input  logic [3:0] flags,   // {N, Z, C, V}
	output logic pass
);

	logic n, z, c, v;

	assign {n, z, c, v} = flags;

	always_comb begin
		case (cond)
			4'b0000: pass = z;                  // EQ
			4'b0001: pass = !z;                 // NE
			4'b0010: pass = c;                  // CS/HS
			4'b0011: pass = !c;                 // CC/LO
			4'b0100: pass = n;                  // MI
			4'b0101: pass = !n;                 // PL
			4'b0110: pass = v;                  // VS
			4'b0111: pass = !v;                 // VC
			4'b1000: pass = c && !z;            // HI
			4'b1001: pass = !c || z;            // LS
			4'b1010: pass = (n == v);           // GE
			4'b1011: pass = (n != v);           // LT
			4'b1100: pass = !z && (n == v);     // GT
			4'b1101: pass = z || (n != v);      // LE
			4'b1110: pass = 1'b1;               // AL
			default: pass = 1'b0;               // 1111 is the unconditional space
		endcase
	end

endmodule

// File: verilog/ldmRegSelector.sv
// LDM/STM register picker, returns the lowest listed register and the remaining list
`timescale 1ns/1ps

module ldmRegSelector (
	input  logic [15:0] regList,    // Registers still to transfer
	output logic [3:0] selReg,      // Lowest set bit index
	output logic [15:0] restList    // regList with selReg removed
);

	// Scan high to low so the lowest hit is the one left standing
	always_comb begin
		selReg = 4'd0;
		for (int i = 15; i >= 0; i--) begin
			if (regList[i]) begin
				selReg = 4'(i);
			end
		end
	end

	// x & (x - 1) drops exactly the lowest set bit
	assign restList = regList & (regList - 16'd1);

	// The rest list only loses the selected register, never gains one
	listShrinks: assert final (
		((restList & ~regList) == 16'h0)
		&& ((regList == 16'h0)
			|| (regList[selReg] && !restList[selReg]
				&& ($countones(restList) == $countones(regList) - 1))));

endmodule

// File: verilog/uopSequencer.sv
// Micro-op sequencer, splits RSR, BL, LDM/STM and post-indexed LDR/STR into single micro-ops
`timescale 1ns/1ps

module uopSequencer (
	input  logic clk,
	input  logic reset,
	input  logic stall,                 // Pipeline stall, freezes the sequence
	input  logic [31:0] instr,          // Decoded instruction, held while holdFetch
	input  logic [3:0] flags,           // {N, Z, C, V}
	input  logic [3:0] classEnable,
	output logic [31:0] uopInstr,
	output uopPkg::uopCtrl_t ctrl,
	output logic [3:0] regFileRz,       // {RA1 mux, fifth bit of WA3, RA2, RA1}
	output logic seqStart
);

	uopPkg::seqState_t state, nextState, ldmNext;
	logic condPass;
	logic isRsr, isBl, isLdm, isPost, startLdm;
	logic [15:0] remList, curList, restList;
	logic [3:0] selReg, kReg, curK;
	logic [4:0] nCount, curN, countNow;
	logic [5:0] offWords;           // Transfer offset in words
	logic lastXfer;
	logic [31:0] ldmUop, ldmWbUop;

	uopCondCheck u_condCheck (
		.cond(instr[31:28]),
		.flags(flags),
		.pass(condPass)
	);

	ldmRegSelector u_regSelector (
		.regList(curList),
		.selReg(selReg),
		.restList(restList)
	);

	// Class decode, misc space (BX, MRS and friends) is kept out of RSR
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4]
		&& !((instr[24:23] == 2'b10) && !instr[20]) && classEnable[uopPkg::enRsr];
	assign isBl = (instr[27:24] == 4'b1011) && classEnable[uopPkg::enBl];
	assign isLdm = (instr[27:25] == 3'b100) && classEnable[uopPkg::enLdm];
	assign isPost = (instr[27:25] == 3'b010) && !instr[24] && !instr[21]
		&& classEnable[uopPkg::enPost];       // Immediate offset, P=0, W=0
	assign startLdm = isLdm && condPass && (instr[15:0] != 16'h0);  // Failed or empty passes through

	// First transfer works straight off instr, later ones off the registered list
	assign countNow = 5'($countones(instr[15:0]));
	assign curList = (state == uopPkg::stLdm) ? remList : instr[15:0];
	assign curK = (state == uopPkg::stLdm) ? kReg : 4'd0;
	assign curN = (state == uopPkg::stReady) ? countNow : nCount;
	assign lastXfer = (restList == 16'h0);
	assign ldmNext = !lastXfer ? uopPkg::stLdm
		: (instr[21] ? uopPkg::stLdmWriteback : uopPkg::stReady);

	// Offset by addressing mode {P, U}
	always_comb begin
		case (instr[24:23])
			2'b01: offWords = {2'b00, curK};                       // IA
			2'b11: offWords = {2'b00, curK} + 6'd1;                // IB
			2'b00: offWords = {1'b0, curN} - {2'b00, curK} - 6'd1; // DA
			default: offWords = {1'b0, curN} - {2'b00, curK};      // DB
		endcase
	end

	// Single word transfer, pre-indexed, no writeback
	assign ldmUop = {instr[31:28], 3'b010, 1'b1, instr[23], 1'b0, 1'b0, instr[20],
		instr[19:16], selReg, 4'h0, offWords, 2'b00};
	// Base update Rn = Rn +/- 4n
	assign ldmWbUop = {instr[31:28], 3'b001, instr[23] ? uopPkg::opAdd : uopPkg::opSub,
		1'b0, instr[19:16], instr[19:16], 5'b00000, curN, 2'b00};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::stReady;
			remList <= 16'h0;
			kReg <= 4'd0;
			nCount <= 5'd0;
		end else if (!stall) begin
			state <= nextState;
			remList <= restList;        // Only meaningful on the way into stLdm
			kReg <= curK + 4'd1;
			nCount <= curN;             // Latched in stReady, held after
		end
	end

	always_comb begin
		nextState = uopPkg::stReady;
		uopInstr = instr;               // Pass-through unless a micro-op takes over
		ctrl = '0;
		regFileRz = 4'b0000;
		case (state)
			uopPkg::stReady: begin
				if (isRsr) begin
					// MOV Rz, Rm <shift> Rs
					uopInstr = {instr[31:25], uopPkg::opMov, 1'b0, 4'h0, uopPkg::regZ,
						instr[11:0]};
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.holdFetch = 1'b1;
					regFileRz = 4'b1100;
					nextState = uopPkg::stRsr;
				end else if (isBl) begin
					// MOV LR, PC
					uopInstr = {instr[31:28], 3'b000, uopPkg::opMov, 1'b0, 4'h0,
						uopPkg::regLink, 8'h00, uopPkg::regPc};
					ctrl.instrMux = 1'b1;
					ctrl.holdFetch = 1'b1;
					nextState = uopPkg::stBl;
				end else if (startLdm) begin
					uopInstr = ldmUop;
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.holdFetch = !lastXfer || instr[21];  // Single reg without W ends here
					nextState = ldmNext;
				end else if (isPost) begin
					// Same access at [Rn] with P=1 U=1 W=0
					uopInstr = {instr[31:28], 3'b010, 1'b1, 1'b1, instr[22], 1'b0,
						instr[20], instr[19:12], 12'h000};
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.holdFetch = 1'b1;
					nextState = uopPkg::stPostIndex;
				end
			end
			uopPkg::stRsr: begin
				uopInstr = {instr[31:12], 8'h00, uopPkg::regZ};  // Original op on Rz
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				regFileRz = 4'b0010;
			end
			uopPkg::stBl: begin
				uopInstr = {instr[31:25], 1'b0, instr[23:0]};    // Plain B
				ctrl.instrMux = 1'b1;
			end
			uopPkg::stLdm: begin
				uopInstr = ldmUop;
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.ldmForward = 1'b1;
				ctrl.holdFetch = !lastXfer || instr[21];
				nextState = ldmNext;
			end
			uopPkg::stLdmWriteback: begin
				uopInstr = ldmWbUop;
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
			end
			uopPkg::stPostIndex: begin
				// Rn = Rn +/- imm12, direction from U
				uopInstr = {instr[31:28], 3'b001,
					instr[23] ? uopPkg::opAdd : uopPkg::opSub, 1'b0,
					instr[19:16], instr[19:16], instr[11:0]};
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.noRotate = 1'b1;
			end
			default: nextState = uopPkg::stReady;
		endcase
	end

	assign seqStart = (state == uopPkg::stReady) && ctrl.instrMux && !stall;

	// Fetch is never held while idle with the instruction passing through
	holdOnlyWhenMux: assert property (@(posedge clk) disable iff (reset)
		((state == uopPkg::stReady) && !ctrl.instrMux) |-> !ctrl.holdFetch);

	// A stalled cycle leaves the sequence where it was
	stallFreeze: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(state));

endmodule

// File: verilog/uopConfigRegs.sv
// AXI4-Lite configuration slave with per-class expansion enables and a start counter
`timescale 1ns/1ps

module uopConfigRegs (
	input  logic clk,
	input  logic reset,
	input  logic [3:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [3:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic seqStart,              // One pulse per started expansion
	output logic [uopPkg::classCount-1:0] classEnable
);

	logic wrAccept;                     // Shared AW/W ready
	logic wrFire, rdFire;
	logic wrCtrl, wrCount, wrMapped, rdMapped;
	logic [31:0] expCount;

	assign awready = wrAccept;
	assign wready = wrAccept;           // Address and data taken in the same beat
	assign wrFire = wrAccept && awvalid && wvalid;
	assign rdFire = arready && arvalid;

	assign wrCtrl = wrFire && (awaddr == uopPkg::addrCtrl);
	assign wrCount = wrFire && (awaddr == uopPkg::addrCount);
	assign wrMapped = (awaddr == uopPkg::addrCtrl) || (awaddr == uopPkg::addrCount);
	assign rdMapped = (araddr == uopPkg::addrCtrl) || (araddr == uopPkg::addrCount);

	// Write channel, one beat at a time, next accept waits for B to drain
	always_ff @(posedge clk) begin
		if (reset) begin
			wrAccept <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			wrAccept <= awvalid && wvalid && !wrAccept && !bvalid;
			if (wrFire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrFire) begin
			bresp <= wrMapped ? uopPkg::respOkay : uopPkg::respSlvErr;
		end
	end

	// Read channel
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rdFire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rdFire) begin
			rresp <= rdMapped ? uopPkg::respOkay : uopPkg::respSlvErr;
			case (araddr)
				uopPkg::addrCtrl: rdata <= {28'h0, classEnable};
				uopPkg::addrCount: rdata <= expCount;
				default: rdata <= 32'h0;   // Unmapped reads as zero
			endcase
		end
	end

	// Enables and counter, a clear write beats a same-cycle start
	always_ff @(posedge clk) begin
		if (reset) begin
			classEnable <= uopPkg::ctrlResetValue;
			expCount <= 32'h0;
		end else begin
			if (wrCtrl && wstrb[0]) begin
				classEnable <= wdata[uopPkg::classCount-1:0];
			end
			if (wrCount && (wstrb != 4'h0)) begin
				expCount <= 32'h0;
			end else if (seqStart) begin
				expCount <= expCount + 32'd1;
			end
		end
	end

	// Write response is not withdrawn before the master takes it
	bvalidHold: assert property (@(posedge clk) disable iff (reset)
		(bvalid && !bready) |=> bvalid);

endmodule

// File: verilog/uopExpander.sv
// Decode-stage micro-op expander top, sequencer plus its AXI4-Lite configuration block
`timescale 1ns/1ps

module uopExpander (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic [31:0] instr,
	input  logic [3:0] flags,
	output logic [31:0] uopInstr,
	output uopPkg::uopCtrl_t ctrl,
	output logic [3:0] regFileRz,
	input  logic [3:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [3:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready
);

	logic seqStart;                                 // Sequencer to counter
	logic [uopPkg::classCount-1:0] classEnable;     // Config to sequencer

	uopSequencer u_uopSequencer (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.flags(flags),
		.classEnable(classEnable),
		.uopInstr(uopInstr),
		.ctrl(ctrl),
		.regFileRz(regFileRz),
		.seqStart(seqStart)
	);

	uopConfigRegs u_uopConfigRegs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.seqStart(seqStart),
		.classEnable(classEnable)
	);

endmodule

// File: bench/uopExpanderTb.sv
// Micro-op expander testbench with directed checks of every expansion class and the AXI4-Lite port
`timescale 1ns/1ps

module uopExpanderTb;

	logic clk, reset, stall;
	logic [31:0] instr, uopInstr;
	logic [3:0] flags, regFileRz;
	uopPkg::uopCtrl_t ctrl;
	logic [3:0] awaddr, araddr, wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [1:0] bresp, rresp;
	logic [31:0] lfsrState;
	int startCount;                     // Expected value of the expansion counter
	logic [31:0] expInstrQ[$];          // Reference micro-op stream
	uopPkg::uopCtrl_t expCtrlQ[$];
	logic [3:0] expRzQ[$];
	logic flagCareQ[$];                 // noFlagUpdate only compared on pass-through

	uopExpander u_uopExpander (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;         // 100 ns period
	end

	task automatic abortRun();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic waitGuard(input int cycles, input string what);
		if (cycles > 20) begin
			$display("Timeout, %s did not complete within 20 cycles", what);
			abortRun();
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;                             // Inputs change just after the edge
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Taps 32 22 2 1
	endfunction

	task automatic takeBits(input int width, output logic [31:0] value);
		value = 32'h0;
		for (int b = 0; b < width; b++) begin
			lfsrState = lfsrNext(lfsrState);  // One step per bit
			value[b] = lfsrState[0];
		end
	endtask

	function automatic uopPkg::uopCtrl_t makeCtrl(input logic hold, input logic fwd,
			input logic rsr2, input logic noRot);
		uopPkg::uopCtrl_t c;
		c = '0;
		c.instrMux = 1'b1;              // Every expanded step replaces instr
		c.holdFetch = hold;
		c.ldmForward = fwd;
		c.prevRsr = rsr2;
		c.noRotate = noRot;
		return c;
	endfunction

	function automatic logic [31:0] ldmWord(input logic [3:0] cond, input logic [1:0] pu,
			input logic wb, input logic load, input logic [3:0] rn, input logic [15:0] list);
		return {cond, 3'b100, pu, 1'b0, wb, load, rn, list};
	endfunction

	task automatic pushUop(input logic [31:0] word, input uopPkg::uopCtrl_t c,
			input logic [3:0] rz, input logic flagCare);
		expInstrQ.push_back(word);
		expCtrlQ.push_back(c);
		expRzQ.push_back(rz);
		flagCareQ.push_back(flagCare);
	endtask

	task automatic passModel(input logic [31:0] w);
		pushUop(w, '0, 4'h0, 1'b1);    // Unchanged with all control low
	endtask

	task automatic rsrModel(input logic [31:0] w);
		// MOV Rz keeps cond, bits 27 to 25 and the shifter operand
		pushUop((w & 32'hFE000FFF) | (32'(uopPkg::opMov) << 21) | (32'(uopPkg::regZ) << 12),
			makeCtrl(1'b1, 1'b0, 1'b0, 1'b0), 4'b1100, 1'b0);
		pushUop((w & 32'hFFFFF000) | 32'(uopPkg::regZ), makeCtrl(1'b0, 1'b0, 1'b1, 1'b0),
			4'b0010, 1'b0);
	endtask

	task automatic blModel(input logic [31:0] w);
		pushUop((w & 32'hF0000000) | (32'(uopPkg::opMov) << 21)
			| (32'(uopPkg::regLink) << 12) | 32'(uopPkg::regPc),
			makeCtrl(1'b1, 1'b0, 1'b0, 1'b0), 4'h0, 1'b0);
		pushUop(w & ~(32'h1 << 24), makeCtrl(1'b0, 1'b0, 1'b0, 1'b0), 4'h0, 1'b0);
	endtask

	task automatic ldmModel(input logic [31:0] w);
		int n, k, off;
		logic last;
		n = $countones(w[15:0]);
		k = 0;
		for (int i = 0; i < 16; i++) begin
			if (w[i]) begin
				case (w[24:23])
					2'b01: off = 4 * k;                 // IA
					2'b11: off = 4 * k + 4;             // IB
					2'b00: off = 4 * (n - 1 - k);       // DA
					default: off = 4 * (n - k);         // DB
				endcase
				last = (k == n - 1) && !w[21];
				pushUop({w[31:28], 3'b010, 1'b1, w[23], 1'b0, 1'b0, w[20], w[19:16], 4'(i),
					12'(off)}, makeCtrl(!last, k > 0, 1'b0, 1'b0), 4'h0, 1'b0);
				k++;
			end
		end
		if (w[21]) begin
			pushUop({w[31:28], 3'b001, w[23] ? uopPkg::opAdd : uopPkg::opSub, 1'b0, w[19:16],
				w[19:16], 12'(4 * n)}, makeCtrl(1'b0, 1'b0, 1'b0, 1'b0), 4'h0, 1'b0);
		end
	endtask

	task automatic postModel(input logic [31:0] w);
		logic [3:0] op;
		op = w[23] ? uopPkg::opAdd : uopPkg::opSub;
		// Set P and U, clear W and the offset
		pushUop((w & ~32'h00200FFF) | 32'h01800000,
			makeCtrl(1'b1, 1'b0, 1'b0, 1'b0), 4'h0, 1'b0);
		// Data processing immediate, Rn kept and copied into Rd
		pushUop((w & 32'hF00F0FFF) | 32'h02000000 | (32'(op) << 21) | (32'(w[19:16]) << 12),
			makeCtrl(1'b0, 1'b0, 1'b0, 1'b1), 4'h0, 1'b0);
	endtask

	task automatic sampleAndCheck(input int i);
		uopPkg::uopCtrl_t got;
		#97;                            // Just before the next edge
		got = ctrl;
		if (!flagCareQ[i]) begin
			got.noFlagUpdate = expCtrlQ[i].noFlagUpdate;
		end
		checkValue("uopInstr", uopInstr, expInstrQ[i]);
		checkValue("ctrl", 32'(got), 32'(expCtrlQ[i]));
		checkValue("regFileRz", 32'(regFileRz), 32'(expRzQ[i]));
	endtask

	// Holds word on instr for the whole reference stream with an optional stall at one step
	task automatic runAndCheck(input logic [31:0] word, input int stallAt, input int stallLen);
		instr = word;
		for (int i = 0; i < expInstrQ.size(); i++) begin
			if (i == stallAt) begin
				for (int s = 0; s < stallLen; s++) begin
					stall = 1'b1;
					sampleAndCheck(i);      // Same micro-op while stalled
					nextCycle();
				end
				stall = 1'b0;
			end
			sampleAndCheck(i);
			nextCycle();
		end
		instr = 32'hE1A00000;           // MOV r0, r0 while idle
		expInstrQ.delete();
		expCtrlQ.delete();
		expRzQ.delete();
		flagCareQ.delete();
	endtask

	task automatic runPass(input logic [31:0] word);
		passModel(word);
		runAndCheck(word, -1, 0);
	endtask

	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int cycles;
		logic done;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			#97;
			done = awready && wready;   // Beat taken on the coming edge
			nextCycle();
			cycles++;
			waitGuard(cycles, "AXI write address and data handshake");
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			#97;
			done = bvalid;
			resp = bresp;
			nextCycle();
			cycles++;
			waitGuard(cycles, "AXI write response");
		end
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int cycles;
		logic done;
		araddr = addr;
		arvalid = 1'b1;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			#97;
			done = arready;
			nextCycle();
			cycles++;
			waitGuard(cycles, "AXI read address handshake");
		end
		arvalid = 1'b0;
		rready = 1'b1;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			#97;
			done = rvalid;
			data = rdata;
			resp = rresp;
			nextCycle();
			cycles++;
			waitGuard(cycles, "AXI read data");
		end
		rready = 1'b0;
	endtask

	task automatic checkCount();
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(uopPkg::addrCount, data, resp);
		checkValue("rresp", 32'(resp), 32'(2'b00));
		checkValue("expansion count", data, 32'(startCount));
	endtask

	task automatic resetAndPassThrough();
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(uopPkg::addrCtrl, data, resp);
		checkValue("rresp", 32'(resp), 32'(2'b00));
		checkValue("class enables", data, 32'h0000000F);
		checkCount();
		runPass({4'hE, 3'b001, uopPkg::opAdd, 1'b0, 4'h1, 4'h2, 12'h005});  // ADD r2, r1, #5
		runPass(ldmWord(4'h0, 2'b01, 1'b1, 1'b1, 4'h2, 16'h00F0));  // LDMEQ with Z clear
		runPass(ldmWord(4'hE, 2'b01, 1'b0, 1'b1, 4'h2, 16'h0000));  // Empty list
		checkCount();
	endtask

	task automatic rsrAndBl();
		logic [31:0] word;
		word = {4'hE, 3'b000, uopPkg::opAdd, 1'b1, 4'h2, 4'h1, 4'h4, 1'b0, 2'b01, 1'b1, 4'h3};
		rsrModel(word);                 // ADDS r1, r2, r3, LSR r4
		runAndCheck(word, -1, 0);
		startCount++;
		checkCount();
		word = {4'hE, 4'b1011, 24'h000123};
		blModel(word);
		runAndCheck(word, -1, 0);
		startCount++;
		checkCount();
	endtask

	task automatic ldmStmModes();
		logic [31:0] list, sel, word;
		for (int mode = 0; mode < 4; mode++) begin
			for (int wb = 0; wb < 2; wb++) begin
				list = 32'h0;
				while (list[15:0] == 16'h0) begin
					takeBits(16, list);
				end
				takeBits(5, sel);       // L bit and Rn
				word = ldmWord(4'h1, 2'(mode), 1'(wb), sel[4], sel[3:0], list[15:0]);
				ldmModel(word);         // NE passes with Z clear
				runAndCheck(word, -1, 0);
				startCount++;
			end
		end
		checkCount();
	endtask

	task automatic postIndexed();
		logic [31:0] word;
		word = {4'hE, 3'b010, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 4'h5, 4'h6, 12'h024};
		postModel(word);                // LDR r6, [r5], #36
		runAndCheck(word, -1, 0);
		word = {4'hE, 3'b010, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4'h7, 4'h8, 12'h3FC};
		postModel(word);                // STRB r8, [r7], #-1020
		runAndCheck(word, -1, 0);
		startCount += 2;
		checkCount();
	endtask

	task automatic stallHold();
		logic [31:0] word;
		word = ldmWord(4'hE, 2'b11, 1'b1, 1'b0, 4'hD, 16'h6962);  // STMIB sp! with 7 regs
		ldmModel(word);
		runAndCheck(word, 3, 4);        // Freeze on the fourth transfer
		startCount++;
		checkCount();
	endtask

	task automatic configAccess();
		logic [31:0] data, blWord, rsrWord;
		logic [1:0] resp;
		rsrWord = {4'hE, 3'b000, uopPkg::opSub, 1'b0, 4'h3, 4'h4, 4'h5, 1'b0, 2'b10, 1'b1, 4'h6};
		blWord = {4'hE, 4'b1011, 24'hFFFFF0};
		axiWrite(uopPkg::addrCtrl, 32'h0000000E, resp);  // RSR off
		checkValue("bresp", 32'(resp), 32'(2'b00));
		runPass(rsrWord);
		blModel(blWord);
		runAndCheck(blWord, -1, 0);
		startCount++;
		axiWrite(uopPkg::addrCtrl, 32'h00000000, resp);  // Everything off
		axiRead(uopPkg::addrCtrl, data, resp);
		checkValue("class enables", data, 32'h00000000);
		runPass(blWord);
		runPass(ldmWord(4'hE, 2'b10, 1'b1, 1'b1, 4'h1, 16'h0303));
		runPass({4'hE, 3'b010, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 4'h2, 4'h3, 12'h010});
		checkCount();
		axiWrite(uopPkg::addrCtrl, 32'h0000000F, resp);
		axiWrite(uopPkg::addrCount, 32'h00000000, resp);  // Clear
		startCount = 0;
		checkCount();
		axiRead(4'h8, data, resp);
		checkValue("unmapped rresp", 32'(resp), 32'(2'b10));
		checkValue("unmapped rdata", data, 32'h00000000);
		axiWrite(4'hC, 32'hFFFFFFFF, resp);
		checkValue("unmapped bresp", 32'(resp), 32'(2'b10));
	endtask

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		instr = 32'hE1A00000;
		flags = 4'b0000;                // Z clear so EQ fails and NE passes
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'h0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsrState = 32'h9f09665b;
		startCount = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		resetAndPassThrough();
		rsrAndBl();
		ldmStmModes();
		postIndexed();
		stallHold();
		configAccess();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: tb.f
verilog/uopPkg.sv
verilog/uopCondCheck.sv
verilog/ldmRegSelector.sv
verilog/uopSequencer.sv
verilog/uopConfigRegs.sv
verilog/uopExpander.sv
bench/uopExpanderTb.sv
